/* hw/dadda_mult_cfg.svh */
`ifndef DADDA_MULT_CFG_SVH
`define DADDA_MULT_CFG_SVH

// operand and product widths
`define DADDA_OP_W   16
`define DADDA_PROD_W (2 * `DADDA_OP_W)

// reduction stages for 16 rows
// column heights step down 13, 9, 6, 4, 3, 2
`define DADDA_STAGES 6

`endif

/* hw/dadda_mult_pkg.sv */
`default_nettype none

`include "dadda_mult_cfg.svh"

package dadda_mult_pkg;

  // multiplier or multiplicand, unsigned
  typedef logic [`DADDA_OP_W-1:0] operand_t;

  // full product, also one reduced row of the tree
  typedef logic [`DADDA_PROD_W-1:0] product_t;

endpackage

`default_nettype wire

/* hw/mult_req_ack.sv */
`timescale 1ns/1ps
`default_nettype none

module mult_req_ack (
  input  wire                       clk,
  input  wire                       rst_n,
  input  wire                       req,
  input  dadda_mult_pkg::operand_t  multpr,
  input  dadda_mult_pkg::operand_t  multpcd,
  output logic                      ack,
  output dadda_mult_pkg::product_t  product,
  output logic                      launch,
  output dadda_mult_pkg::operand_t  op_a,
  output dadda_mult_pkg::operand_t  op_b,
  input  wire                       sum_valid,
  input  dadda_mult_pkg::product_t  sum
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_BUSY,
    ST_ACK
  } state_t;

  state_t state;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= ST_IDLE;
      launch  <= 1'b0;
      ack     <= 1'b0;
      product <= '0;
    end else begin
      launch <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (req) begin
            state  <= ST_BUSY;
            launch <= 1'b1;
          end
        end
        ST_BUSY: begin
          // wait for the adder stage
          if (sum_valid) begin
            product <= sum;
            ack     <= 1'b1;
            state   <= ST_ACK;
          end
        end
        ST_ACK: begin
          if (!req) begin
            ack   <= 1'b0;
            state <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // operands only taken on acceptance
  always_ff @(posedge clk) begin
    if (state == ST_IDLE && req) begin
      op_a <= multpr;
      op_b <= multpcd;
    end
  end

  a_ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(ack) |-> $past(req));

  a_product_held: assert property (@(posedge clk) disable iff (!rst_n)
    ack && $past(ack) |-> $stable(product));

  a_sum_when_busy: assert property (@(posedge clk) disable iff (!rst_n)
    sum_valid |-> state == ST_BUSY);

endmodule

`default_nettype wire

/* hw/dadda_tree.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dadda_mult_cfg.svh"

module dadda_tree (
  input  wire                       clk,
  input  wire                       rst_n,
  input  wire                       launch,
  input  dadda_mult_pkg::operand_t  op_a,
  input  dadda_mult_pkg::operand_t  op_b,
  output logic                      rows_valid,
  output dadda_mult_pkg::product_t  sum_row,
  output dadda_mult_pkg::product_t  carry_row
);

  import dadda_mult_pkg::*;

  localparam int W    = `DADDA_OP_W;
  localparam int NCOL = `DADDA_PROD_W;
  // tallest column of the raw array
  localparam int MAXH = `DADDA_OP_W;

  product_t sum_next;
  product_t carry_next;

  // target height of stage k, counted up from the final 2
  function automatic int stage_height(input int k);
    int d;
    d = 2;
    for (int n = 1; n < k; n++) begin
      d = (d * 3) / 2;
    end
    return d;
  endfunction

  always_comb begin : reduce
    logic [NCOL-1:0][MAXH-1:0] col;
    logic [NCOL-1:0][MAXH-1:0] nxt;
    int              h [NCOL];
    logic [MAXH-1:0] cy;
    logic [MAXH-1:0] cy_prev;
    int              n_prev;
    int              d;
    int              fa;
    int              ha;
    int              used;
    int              k_out;
    logic            x0;
    logic            x1;
    logic            x2;

    x0 = 1'b0;
    x1 = 1'b0;
    x2 = 1'b0;
    col = '0;
    for (int c = 0; c < NCOL; c++) begin
      h[c] = 0;
    end

    // and array, bit (i, j) has weight i + j
    for (int i = 0; i < W; i++) begin
      for (int j = 0; j < W; j++) begin
        col[i+j][h[i+j]] = op_a[j] & op_b[i];
        h[i+j] = h[i+j] + 1;
      end
    end

    for (int s = 0; s < `DADDA_STAGES; s++) begin
      d = stage_height(`DADDA_STAGES - s);
      nxt = '0;
      cy_prev = '0;
      n_prev = 0;
      for (int c = 0; c < NCOL; c++) begin
        fa = 0;
        ha = 0;
        // incoming carries count toward this column's height
        if (h[c] + n_prev > d) begin
          fa = (h[c] + n_prev - d) / 2;
          ha = (h[c] + n_prev - d) % 2;
        end
        cy = '0;
        k_out = 0;
        for (int k = 0; k < MAXH / 3; k++) begin
          if (k < fa) begin
            x0 = col[c][3*k];
            x1 = col[c][3*k+1];
            x2 = col[c][3*k+2];
            nxt[c][k_out] = x0 ^ x1 ^ x2;
            cy[k] = (x0 & x1) | (x2 & (x0 | x1));
            k_out++;
          end
        end
        if (ha == 1) begin
          x0 = col[c][3*fa];
          x1 = col[c][3*fa+1];
          nxt[c][k_out] = x0 ^ x1;
          cy[fa] = x0 & x1;
          k_out++;
        end
        // untouched bits pass straight down
        used = 3 * fa + 2 * ha;
        for (int k = 0; k < MAXH; k++) begin
          if (k >= used && k < h[c]) begin
            nxt[c][k_out] = col[c][k];
            k_out++;
          end
        end
        for (int k = 0; k < MAXH; k++) begin
          if (k < n_prev) begin
            nxt[c][k_out] = cy_prev[k];
            k_out++;
          end
        end
        h[c] = k_out;
        cy_prev = cy;
        n_prev = fa + ha;
      end
      col = nxt;
    end

    // at most two bits left per column
    for (int c = 0; c < NCOL; c++) begin
      sum_next[c]   = col[c][0];
      carry_next[c] = col[c][1];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rows_valid <= 1'b0;
    end else begin
      rows_valid <= launch;
    end
  end

  always_ff @(posedge clk) begin
    if (launch) begin
      sum_row   <= sum_next;
      carry_row <= carry_next;
    end
  end

endmodule

`default_nettype wire

/* hw/brent_kung_adder.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dadda_mult_cfg.svh"

module brent_kung_adder (
  input  wire                       clk,
  input  wire                       rst_n,
  input  wire                       rows_valid,
  input  dadda_mult_pkg::product_t  sum_row,
  input  dadda_mult_pkg::product_t  carry_row,
  output logic                      sum_valid,
  output dadda_mult_pkg::product_t  sum
);

  import dadda_mult_pkg::*;

  localparam int W      = `DADDA_PROD_W;
  localparam int LEVELS = $clog2(`DADDA_PROD_W);

  product_t sum_next;

  always_comb begin : prefix
    product_t prop;
    product_t g;
    product_t p;
    product_t carry;
    int       d;

    prop = sum_row ^ carry_row;
    g    = sum_row & carry_row;
    p    = prop;

    // up-sweep, pairs at distance 1, 2, 4, 8, 16
    for (int lvl = 0; lvl < LEVELS; lvl++) begin
      d = 1 << lvl;
      for (int i = 2 * d - 1; i < W; i += 2 * d) begin
        g[i] = g[i] | (p[i] & g[i-d]);
        p[i] = p[i] & p[i-d];
      end
    end

    // down-sweep fills the carries between the tree nodes
    for (int lvl = LEVELS - 2; lvl >= 0; lvl--) begin
      d = 1 << lvl;
      for (int i = 3 * d - 1; i < W; i += 2 * d) begin
        g[i] = g[i] | (p[i] & g[i-d]);
      end
    end

    // g[i] now covers bits i..0, carry-in is zero
    carry = {g[W-2:0], 1'b0};
    sum_next = prop ^ carry;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sum_valid <= 1'b0;
    end else begin
      sum_valid <= rows_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (rows_valid) begin
      sum <= sum_next;
    end
  end

  a_single_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    sum_valid |=> !sum_valid);

endmodule

`default_nettype wire

/* hw/dadda_mult_top.sv */
`timescale 1ns/1ps
`default_nettype none

module dadda_mult_top (
  input  wire                       clk,
  input  wire                       rst_n,
  input  wire                       req,
  input  dadda_mult_pkg::operand_t  multpr,
  input  dadda_mult_pkg::operand_t  multpcd,
  output logic                      ack,
  output dadda_mult_pkg::product_t  product
);

  import dadda_mult_pkg::*;

  logic     launch;
  operand_t op_a;
  operand_t op_b;
  logic     rows_valid;
  product_t sum_row;
  product_t carry_row;
  logic     sum_valid;
  product_t sum;

  mult_req_ack mult_req_ack_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .req       (req),
    .multpr    (multpr),
    .multpcd   (multpcd),
    .ack       (ack),
    .product   (product),
    .launch    (launch),
    .op_a      (op_a),
    .op_b      (op_b),
    .sum_valid (sum_valid),
    .sum       (sum)
  );

  // partial products and reduction to two rows
  dadda_tree dadda_tree_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .launch     (launch),
    .op_a       (op_a),
    .op_b       (op_b),
    .rows_valid (rows_valid),
    .sum_row    (sum_row),
    .carry_row  (carry_row)
  );

  brent_kung_adder brent_kung_adder_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .rows_valid (rows_valid),
    .sum_row    (sum_row),
    .carry_row  (carry_row),
    .sum_valid  (sum_valid),
    .sum        (sum)
  );

endmodule

`default_nettype wire

/* test/tb_dadda_mult.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_dadda_mult;

  import dadda_mult_pkg::*;

  localparam int TIMEOUT = 20;

  logic     clk;
  logic     rst_n;
  logic     req;
  operand_t multpr;
  operand_t multpcd;
  logic     ack;
  product_t product;

  integer   seed;

  dadda_mult_top dadda_mult_top_inst (
    .clk     (clk),
    .rst_n   (rst_n),
    .req     (req),
    .multpr  (multpr),
    .multpcd (multpcd),
    .ack     (ack),
    .product (product)
  );

  always #20 clk = ~clk;

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Result: FAILED");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic check_product(input string name, input product_t exp, input product_t act);
    if (act !== exp) begin
      abort_run($sformatf("ERR t=%0t %s expected=%h actual=%h", $time, name, exp, act));
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      abort_run($sformatf("ERR t=%0t %s expected=%b actual=%b", $time, name, exp, act));
    end
  endtask

  task automatic check_cycles(input string name, input int exp, input int act);
    if (act != exp) begin
      abort_run($sformatf("ERR t=%0t %s expected=%0d actual=%0d", $time, name, exp, act));
    end
  endtask

  // one four-phase transaction, hold keeps req high for extra cycles
  task automatic do_mult(input operand_t a, input operand_t b, input int hold);
    int       n;
    product_t exp;
    exp = product_t'(a) * product_t'(b);
    multpr = a;
    multpcd = b;
    req = 1'b1;
    n = 0;
    do begin
      @(posedge clk);
      #2;
      n++;
      // scrambled operands while busy must not leak in
      if (hold > 0) begin
        multpr = operand_t'($random(seed));
        multpcd = operand_t'($random(seed));
      end
    end while (!ack && n < TIMEOUT);
    if (!ack) abort_run("timeout: ack never rose after req");
    // first edge in the loop is the accepting edge
    check_cycles("ack latency", 3, n - 1);
    check_product("product", exp, product);
    for (int i = 0; i < hold; i++) begin
      multpr = operand_t'($random(seed));
      multpcd = operand_t'($random(seed));
      @(posedge clk);
      #2;
      check_bit("ack", 1'b1, ack);
      check_product("product", exp, product);
    end
    req = 1'b0;
    n = 0;
    do begin
      @(posedge clk);
      #2;
      n++;
    end while (ack && n < TIMEOUT);
    if (ack) abort_run("timeout: ack stayed high after req dropped");
    check_cycles("ack fall edges", 1, n);
  endtask

  task automatic test_reset();
    check_bit("ack", 1'b0, ack);
    check_product("product", '0, product);
  endtask

  task automatic test_corners();
    do_mult(16'd0, 16'd65535, 0);
    do_mult(16'd1, 16'hbeef, 0);
    do_mult(16'h3c71, 16'd1, 0);
    do_mult(16'd65535, 16'd65535, 0);
    do_mult(16'd32768, 16'd32768, 0);
    do_mult(16'haaaa, 16'h5555, 0);
    do_mult(16'h5555, 16'h5555, 0);
    do_mult(16'haaaa, 16'haaaa, 0);
    // walking one on multpr
    for (int i = 0; i < 16; i++) begin
      do_mult(operand_t'(1 << i), 16'hc3a5, 0);
      do_mult(operand_t'(1 << i), 16'hffff, 0);
    end
  endtask

  task automatic test_random();
    operand_t a;
    operand_t b;
    for (int i = 0; i < 200; i++) begin
      a = operand_t'($random(seed));
      b = operand_t'($random(seed));
      do_mult(a, b, 0);
    end
  endtask

  task automatic test_hold_release();
    do_mult(16'hbeef, 16'h1234, 10);
    // next transaction must bring its own result
    do_mult(16'h00ff, 16'hff00, 0);
  endtask

  initial begin
    clk = 1'b0;
    rst_n = 1'b0;
    req = 1'b0;
    multpr = '0;
    multpcd = '0;
    seed = 32'h2a3;
    repeat (8) @(posedge clk);
    #2;
    rst_n = 1'b1;
    @(posedge clk);
    #2;
    test_reset();
    test_corners();
    test_random();
    test_hold_release();
    $display("Result: PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* dadda_mult.f */
+incdir+hw
hw/dadda_mult_pkg.sv
hw/mult_req_ack.sv
hw/dadda_tree.sv
hw/brent_kung_adder.sv
hw/dadda_mult_top.sv
test/tb_dadda_mult.sv

/* run_sim.sh */
#!/bin/sh
# build the testbench with Verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  --top-module tb_dadda_mult \
  -f dadda_mult.f \
  -o tb_dadda_mult_sim \
  && ./obj_dir/tb_dadda_mult_sim | tee /dev/stderr | grep -q "Result: PASSED" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
